// File: rs232_mem_core.f
source/mem_core_pkg.sv
source/mem_bus_if.sv
source/serial_rx.sv
source/serial_tx.sv
source/cmd_sequencer.sv
source/erase_unit.sv
source/rs232_mem_core.sv
bench/rs232_mem_core_asserts.sv
bench/rs232_mem_core_tb.sv

// File: bench/rs232_mem_core_tb.sv
`timescale 1ns/100ps

module rs232_mem_core_tb;

  localparam int ADDR_W = mem_core_pkg::DEF_ADDR_W;
  localparam int DEPTH  = 2 ** ADDR_W;

  logic              clk;
  logic              rst;
  logic              new_word;
  logic              data_rs232_in;
  logic              send_word;
  logic              data_rs232_out;
  logic              end_of_erase;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_write;
  logic [7:0]        mem_data_in;
  logic [7:0]        mem_data_out;

  logic [7:0]  mem [DEPTH];                          // External memory
  logic [7:0]  exp_mem [DEPTH];                      // Expected contents
  logic        prot_model;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          test_errors;
  int          eoe_count;

  rs232_mem_core #(.ADDR_W(ADDR_W)) i_dut (
    .clk            (clk),
    .rst            (rst),
    .new_word       (new_word),
    .data_rs232_in  (data_rs232_in),
    .send_word      (send_word),
    .data_rs232_out (data_rs232_out),
    .end_of_erase   (end_of_erase),
    .mem_addr       (mem_addr),
    .mem_write      (mem_write),
    .mem_data_in    (mem_data_in),
    .mem_data_out   (mem_data_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign mem_data_out = mem[mem_addr];               // Asynchronous read

  always @(posedge clk)
  begin
    if (mem_write)
      mem[mem_addr] <= mem_data_in;
  end

  always @(negedge clk)
  begin
    if (end_of_erase)
      eoe_count++;
  end

  function automatic logic [7:0] rand_byte();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[23:16];
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // Strobe then eight bits MSB first, with idle time so the receiver is back in idle
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    new_word = 1'b1;
    for (int i = 7; i >= 0; i--)
    begin
      @(negedge clk);
      new_word      = 1'b0;
      data_rs232_in = b[i];
    end
    @(negedge clk);
    data_rs232_in = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic expect_reply(input logic [7:0] exp);
    int         wait_cnt;
    logic [7:0] got;
    wait_cnt = 0;
    while (!send_word)
    begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 200)
        stop_on_timeout("send_word");
    end
    for (int i = 0; i < 8; i++)
    begin
      got = {got[6:0], data_rs232_out};              // One bit per send_word cycle
      @(negedge clk);
    end
    check_value("data_rs232_out", got, exp);
  endtask

  task automatic do_write(input logic [7:0] a, input logic [7:0] d);
    send_byte(8'hC0 | (rand_byte() & 8'h3F));
    send_byte(a);
    send_byte(d);
    if (prot_model)
      expect_reply(mem_core_pkg::NAK_WORD);
    else
    begin
      exp_mem[a] = d;
      expect_reply(mem_core_pkg::ACK_WORD);
    end
    check_value($sformatf("mem[%02h]", a), mem[a], exp_mem[a]);
  endtask

  task automatic do_read(input logic [7:0] a, input logic erasing);
    send_byte(8'h80 | (rand_byte() & 8'h3F));
    send_byte(a);
    if (erasing)
      expect_reply(mem_core_pkg::NAK_WORD);
    else
    begin
      expect_reply(exp_mem[a]);
      expect_reply(mem_core_pkg::ACK_WORD);
    end
  endtask

  task automatic do_protect(input logic [7:0] key1, input logic [7:0] key2,
                            input logic [7:0] exp);
    send_byte(8'h05);
    send_byte(key1);
    send_byte(key2);
    expect_reply(exp);
  endtask

  task automatic check_memory();
    for (int a = 0; a < DEPTH; a++)
      check_value($sformatf("mem[%02h]", a[7:0]), mem[a], exp_mem[a]);
  endtask

  task automatic wait_erase_end();
    int wait_cnt;
    wait_cnt = 0;
    while (eoe_count == 0)
    begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > DEPTH + 100)
        stop_on_timeout("end_of_erase");
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  initial
  begin
    logic [7:0] d;
    logic [7:0] fill;
    logic [7:0] addrs [8];
    rst           = 1'b1;
    new_word      = 1'b0;
    data_rs232_in = 1'b0;
    rng_state     = 32'hd33858c1;
    errors        = 0;
    checks        = 0;
    test_errors   = 0;
    eoe_count     = 0;
    prot_model    = 1'b1;                            // Protected out of reset
    for (int i = 0; i < DEPTH; i++)
    begin
      mem[i]     = 8'(i * 37 + 11);
      exp_mem[i] = mem[i];
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    do_write(rand_byte(), rand_byte());
    end_test("protected write");

    do_protect(mem_core_pkg::PROT_OFF_1, mem_core_pkg::PROT_OFF_2, mem_core_pkg::POFF_WORD);
    prot_model = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = rand_byte();
      do_write(addrs[i], rand_byte());
    end
    for (int i = 0; i < 8; i++)
      do_read(addrs[i], 1'b0);
    do_read(rand_byte(), 1'b0);
    end_test("unprotected write and read");

    d = rand_byte() & 8'h3F;
    if (d == 8'h05)
      d = 8'h06;
    send_byte(d);                                    // Protection header, wrong low bits
    expect_reply(mem_core_pkg::NAK_WORD);
    do_protect(mem_core_pkg::PROT_ON_1, mem_core_pkg::PROT_OFF_2, mem_core_pkg::NAK_WORD);
    d = rand_byte();
    if (d == mem_core_pkg::ERASE_KEY)
      d = d + 8'd1;
    send_byte(8'h40);
    send_byte(d);
    expect_reply(mem_core_pkg::NAK_WORD);
    do_write(rand_byte(), rand_byte());              // Still unprotected
    check_value("end_of_erase count", 8'(eoe_count), 8'd0);
    end_test("malformed sequences");

    fill = rand_byte();
    send_byte(8'h40 | (rand_byte() & 8'h3F));
    send_byte(mem_core_pkg::ERASE_KEY);
    send_byte(fill);
    expect_reply(mem_core_pkg::ACK_WORD);
    do_read(rand_byte(), 1'b1);                      // Sweep still running
    wait_erase_end();
    repeat (20) @(negedge clk);
    check_value("end_of_erase count", 8'(eoe_count), 8'd1);
    for (int i = 0; i < DEPTH; i++)
      exp_mem[i] = fill;
    check_memory();
    for (int i = 0; i < 4; i++)
      do_read(rand_byte(), 1'b0);
    end_test("erase");

    do_protect(mem_core_pkg::PROT_ON_1, mem_core_pkg::PROT_ON_2, mem_core_pkg::PRON_WORD);
    prot_model = 1'b1;
    do_write(addrs[0], ~exp_mem[addrs[0]]);
    do_read(addrs[0], 1'b0);
    end_test("protect again");

    errors = errors + i_dut.i_asserts.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_dut.i_asserts.fail_count);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: bench/rs232_mem_core_asserts.sv
`timescale 1ns/100ps

module rs232_mem_core_asserts (
  input logic clk,
  input logic rst,
  input logic send_word,
  input logic end_of_erase,
  input logic mem_write
);

  int fail_count = 0;                                // Read by the testbench at the end

  // Reply frame is eight bit times long
  assert property (@(posedge clk) disable iff (rst)
                   $rose(send_word) |-> send_word [*8] ##1 !send_word)
  else
  begin
    $error("send_word frame is not exactly 8 cycles long");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (rst) end_of_erase |=> !end_of_erase)
  else
  begin
    $error("end_of_erase is high for more than one cycle");
    fail_count++;
  end

  assert property (@(posedge clk) rst |-> !mem_write && !send_word && !end_of_erase)
  else
  begin
    $error("Output active while reset is asserted");
    fail_count++;
  end

endmodule

bind rs232_mem_core rs232_mem_core_asserts i_asserts (
  .clk          (clk),
  .rst          (rst),
  .send_word    (send_word),
  .end_of_erase (end_of_erase),
  .mem_write    (mem_write)
);

// File: source/rs232_mem_core.sv
`timescale 1ns/100ps

module rs232_mem_core #(
  parameter int ADDR_W = mem_core_pkg::DEF_ADDR_W
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            new_word,
  input  logic                            data_rs232_in,
  output logic                            send_word,
  output logic                            data_rs232_out,
  output logic                            end_of_erase,
  output logic [ADDR_W-1:0]               mem_addr,
  output logic                            mem_write,
  output logic [mem_core_pkg::WORD_W-1:0] mem_data_in,
  input  logic [mem_core_pkg::WORD_W-1:0] mem_data_out
);

  logic [mem_core_pkg::WORD_W-1:0] rx_word;
  logic                            rx_valid;
  logic [mem_core_pkg::WORD_W-1:0] tx_byte;
  logic                            tx_load;
  logic                            tx_ready;

  mem_bus_if #(.ADDR_W(ADDR_W)) mem_bus ();          // Sequencer to erase unit

  serial_rx i_serial_rx (
    .clk           (clk),
    .rst           (rst),
    .new_word      (new_word),
    .data_rs232_in (data_rs232_in),
    .rx_word       (rx_word),
    .rx_valid      (rx_valid)
  );

  cmd_sequencer #(.ADDR_W(ADDR_W)) i_cmd_sequencer (
    .clk      (clk),
    .rst      (rst),
    .rx_word  (rx_word),
    .rx_valid (rx_valid),
    .tx_ready (tx_ready),
    .tx_byte  (tx_byte),
    .tx_load  (tx_load),
    .bus      (mem_bus.seq)
  );

  erase_unit #(.ADDR_W(ADDR_W)) i_erase_unit (
    .clk          (clk),
    .rst          (rst),
    .end_of_erase (end_of_erase),
    .bus          (mem_bus.mem),
    .mem_addr     (mem_addr),
    .mem_write    (mem_write),
    .mem_data_in  (mem_data_in),
    .mem_data_out (mem_data_out)
  );

  serial_tx i_serial_tx (
    .clk            (clk),
    .rst            (rst),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .tx_ready       (tx_ready),
    .send_word      (send_word),
    .data_rs232_out (data_rs232_out)
  );

endmodule

// File: source/erase_unit.sv
`timescale 1ns/100ps

module erase_unit #(
  parameter int ADDR_W = mem_core_pkg::DEF_ADDR_W
) (
  input  logic                            clk,
  input  logic                            rst,
  output logic                            end_of_erase,
  mem_bus_if.mem                          bus,
  output logic [ADDR_W-1:0]               mem_addr,
  output logic                            mem_write,
  output logic [mem_core_pkg::WORD_W-1:0] mem_data_in,
  input  logic [mem_core_pkg::WORD_W-1:0] mem_data_out
);

  logic [ADDR_W:0]                 er_cnt;           // Extra bit flags the wrap
  logic [ADDR_W:0]                 er_cnt_inc;
  logic [mem_core_pkg::WORD_W-1:0] fill_q;
  logic                            busy_q;

  assign er_cnt_inc = er_cnt + 1'b1;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy_q       <= 1'b0;
      er_cnt       <= '0;
      end_of_erase <= 1'b0;
    end
    else
    begin
      end_of_erase <= 1'b0;
      if (bus.erase_start)
      begin
        busy_q <= 1'b1;                              // A new start restarts the sweep
        er_cnt <= '0;
      end
      else if (busy_q)
      begin
        if (er_cnt_inc[ADDR_W])
        begin
          busy_q       <= 1'b0;                      // Top address written this cycle
          end_of_erase <= 1'b1;
          er_cnt       <= '0;
        end
        else
          er_cnt <= er_cnt_inc;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus.erase_start)
      fill_q <= bus.fill;
  end

  // Sequencer owns the memory port only while idle
  assign mem_addr    = busy_q ? er_cnt[ADDR_W-1:0] : bus.addr;
  assign mem_write   = busy_q ? 1'b1 : bus.write;
  assign mem_data_in = busy_q ? fill_q : bus.wdata;

  assign bus.rdata = mem_data_out;
  assign bus.busy  = busy_q;

endmodule

// File: source/cmd_sequencer.sv
`timescale 1ns/100ps

module cmd_sequencer #(
  parameter int ADDR_W = mem_core_pkg::DEF_ADDR_W
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [mem_core_pkg::WORD_W-1:0] rx_word,
  input  logic                            rx_valid,
  input  logic                            tx_ready,
  output logic [mem_core_pkg::WORD_W-1:0] tx_byte,
  output logic                            tx_load,
  mem_bus_if.seq                          bus
);

  localparam int WORD_W = mem_core_pkg::WORD_W;

  localparam logic [3:0] S_FETCH    = 4'd0;
  localparam logic [3:0] S_DECODE   = 4'd1;
  localparam logic [3:0] S_WR_ADDR  = 4'd2;
  localparam logic [3:0] S_WR_DATA  = 4'd3;
  localparam logic [3:0] S_WR_EXEC  = 4'd4;
  localparam logic [3:0] S_RD_ADDR  = 4'd5;
  localparam logic [3:0] S_RD_EXEC  = 4'd6;
  localparam logic [3:0] S_RD_DATA  = 4'd7;
  localparam logic [3:0] S_ER_KEY   = 4'd8;
  localparam logic [3:0] S_ER_FILL  = 4'd9;
  localparam logic [3:0] S_PR_KEY1  = 4'd10;
  localparam logic [3:0] S_PR_ON    = 4'd11;
  localparam logic [3:0] S_PR_OFF   = 4'd12;
  localparam logic [3:0] S_PR_REPLY = 4'd13;
  localparam logic [3:0] S_ACK      = 4'd14;
  localparam logic [3:0] S_NAK      = 4'd15;

  logic [3:0]        state;
  logic [3:0]        state_nxt;
  logic [1:0]        cmd_q;                          // Header bits 7..6
  logic [5:0]        hdr_q;                          // Header bits 5..0
  logic [ADDR_W-1:0] addr_q;
  logic [WORD_W-1:0] data_q;                         // Write data or read result
  logic              prot;
  logic              reply_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= S_FETCH;
    else
      state <= state_nxt;
  end

  // Write protection, on out of reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      prot <= 1'b1;
    else if (state == S_PR_ON && rx_valid && rx_word == mem_core_pkg::PROT_ON_2)
      prot <= 1'b1;
    else if (state == S_PR_OFF && rx_valid && rx_word == mem_core_pkg::PROT_OFF_2)
      prot <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (state == S_FETCH && rx_valid)
    begin
      cmd_q <= rx_word[WORD_W-1 -: 2];
      hdr_q <= rx_word[5:0];
    end
    if ((state == S_WR_ADDR || state == S_RD_ADDR) && rx_valid)
      addr_q <= ADDR_W'(rx_word);
    if (state == S_WR_DATA && rx_valid)
      data_q <= rx_word;
    else if (state == S_RD_EXEC && !bus.busy)
      data_q <= bus.rdata;                           // Async memory read, addr held a cycle
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_FETCH:
        if (rx_valid)
          state_nxt = S_DECODE;
      S_DECODE:
        case (cmd_q)
          mem_core_pkg::CMD_WR: state_nxt = S_WR_ADDR;
          mem_core_pkg::CMD_RD: state_nxt = S_RD_ADDR;
          mem_core_pkg::CMD_ER: state_nxt = S_ER_KEY;
          mem_core_pkg::CMD_PR:
            state_nxt = (hdr_q == mem_core_pkg::PRCH_ADDR) ? S_PR_KEY1 : S_NAK;
          default: state_nxt = S_NAK;
        endcase
      S_WR_ADDR:
        if (rx_valid)
          state_nxt = S_WR_DATA;
      S_WR_DATA:
        if (rx_valid)
          state_nxt = S_WR_EXEC;
      S_WR_EXEC:
        state_nxt = (prot || bus.busy) ? S_NAK : S_ACK;
      S_RD_ADDR:
        if (rx_valid)
          state_nxt = S_RD_EXEC;
      S_RD_EXEC:
        state_nxt = bus.busy ? S_NAK : S_RD_DATA;
      S_RD_DATA:
        if (tx_ready)
          state_nxt = S_ACK;                         // Data byte first, ACK after
      S_ER_KEY:
        if (rx_valid)
          state_nxt = (rx_word == mem_core_pkg::ERASE_KEY) ? S_ER_FILL : S_NAK;
      S_ER_FILL:
        if (rx_valid)
          state_nxt = S_ACK;                         // ACK goes out during the sweep
      S_PR_KEY1:
        if (rx_valid)
        begin
          if (rx_word == mem_core_pkg::PROT_ON_1)
            state_nxt = S_PR_ON;
          else if (rx_word == mem_core_pkg::PROT_OFF_1)
            state_nxt = S_PR_OFF;
          else
            state_nxt = S_NAK;
        end
      S_PR_ON:
        if (rx_valid)
          state_nxt = (rx_word == mem_core_pkg::PROT_ON_2) ? S_PR_REPLY : S_NAK;
      S_PR_OFF:
        if (rx_valid)
          state_nxt = (rx_word == mem_core_pkg::PROT_OFF_2) ? S_PR_REPLY : S_NAK;
      S_PR_REPLY, S_ACK, S_NAK:
        if (tx_ready)
          state_nxt = S_FETCH;
      default: state_nxt = S_FETCH;
    endcase
  end

  // Reply byte per state; held until the transmitter is free
  always_comb
  begin
    reply_state = 1'b1;
    case (state)
      S_RD_DATA:  tx_byte = data_q;
      S_ACK:      tx_byte = mem_core_pkg::ACK_WORD;
      S_NAK:      tx_byte = mem_core_pkg::NAK_WORD;
      S_PR_REPLY: tx_byte = prot ? mem_core_pkg::PRON_WORD : mem_core_pkg::POFF_WORD;
      default:
      begin
        reply_state = 1'b0;
        tx_byte     = '0;
      end
    endcase
  end

  assign tx_load = reply_state && tx_ready;

  assign bus.addr        = addr_q;
  assign bus.wdata       = data_q;
  assign bus.write       = (state == S_WR_EXEC) && !prot && !bus.busy;
  assign bus.erase_start = (state == S_ER_FILL) && rx_valid;  // Accepted even when protected
  assign bus.fill        = rx_word;

endmodule

// File: source/serial_tx.sv
`timescale 1ns/100ps

module serial_tx (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [mem_core_pkg::WORD_W-1:0] tx_byte,
  input  logic                            tx_load,
  output logic                            tx_ready,
  output logic                            send_word,
  output logic                            data_rs232_out
);

  localparam int WORD_W = mem_core_pkg::WORD_W;
  localparam int CNT_W  = $clog2(WORD_W + 1);

  localparam logic [1:0] TX_IDLE  = 2'd0;
  localparam logic [1:0] TX_START = 2'd1;
  localparam logic [1:0] TX_SEND  = 2'd2;

  logic [1:0]        state;
  logic [CNT_W-1:0]  bit_cnt;
  logic [WORD_W-1:0] shreg;

  assign tx_ready = (state == TX_IDLE);              // Drops right after a load

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state          <= TX_IDLE;
      bit_cnt        <= '0;
      send_word      <= 1'b0;
      data_rs232_out <= 1'b0;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (tx_load)
            state <= TX_START;
        end
        TX_START:
        begin
          send_word      <= 1'b1;
          data_rs232_out <= shreg[WORD_W-1];         // Bit 7 with rising send_word
          bit_cnt        <= CNT_W'(1);
          state          <= TX_SEND;
        end
        TX_SEND:
        begin
          if (bit_cnt == CNT_W'(WORD_W))
          begin
            send_word      <= 1'b0;                  // All bits out
            data_rs232_out <= 1'b0;
            bit_cnt        <= '0;
            state          <= TX_IDLE;
          end
          else
          begin
            data_rs232_out <= shreg[WORD_W-1];
            bit_cnt        <= bit_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == TX_IDLE && tx_load)
      shreg <= tx_byte;                              // Latch reply byte
    else if (state != TX_IDLE)
      shreg <= {shreg[WORD_W-2:0], 1'b0};
  end

endmodule

// File: source/serial_rx.sv
`timescale 1ns/100ps

module serial_rx (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            new_word,
  input  logic                            data_rs232_in,
  output logic [mem_core_pkg::WORD_W-1:0] rx_word,
  output logic                            rx_valid
);

  localparam int WORD_W = mem_core_pkg::WORD_W;
  localparam int CNT_W  = $clog2(WORD_W);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_SHIFT = 2'd1;
  localparam logic [1:0] RX_DONE  = 2'd2;

  logic [1:0]       state;
  logic [CNT_W-1:0] bit_cnt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          bit_cnt <= '0;
          if (new_word)
            state <= RX_SHIFT;                       // Bits follow from next edge
        end
        RX_SHIFT:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(WORD_W - 1))
            state <= RX_DONE;                        // Last bit taken this edge
        end
        RX_DONE:
        begin
          rx_valid <= 1'b1;
          state    <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // MSB arrives first, so shift towards the top
  always_ff @(posedge clk)
  begin
    if (state == RX_SHIFT)
      rx_word <= {rx_word[WORD_W-2:0], data_rs232_in};
  end

endmodule

// File: source/mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if #(
  parameter int ADDR_W = mem_core_pkg::DEF_ADDR_W
);

  logic [ADDR_W-1:0]               addr;
  logic [mem_core_pkg::WORD_W-1:0] wdata;
  logic                            write;        // Single-cycle write request
  logic [mem_core_pkg::WORD_W-1:0] rdata;
  logic                            busy;         // Erase sweep running
  logic                            erase_start;
  logic [mem_core_pkg::WORD_W-1:0] fill;         // Valid with erase_start

  modport seq (
    output addr, wdata, write, erase_start, fill,
    input  rdata, busy
  );

  modport mem (
    input  addr, wdata, write, erase_start, fill,
    output rdata, busy
  );

endinterface

// File: source/mem_core_pkg.sv
package mem_core_pkg;

  // Serial word and data width
  localparam int WORD_W     = 8;
  localparam int DEF_ADDR_W = 8;                     // Default memory address width

  // Command codes from header bits 7..6
  localparam logic [1:0] CMD_WR = 2'd3;
  localparam logic [1:0] CMD_RD = 2'd2;
  localparam logic [1:0] CMD_ER = 2'd1;
  localparam logic [1:0] CMD_PR = 2'd0;

  // Reply words
  localparam logic [WORD_W-1:0] ACK_WORD  = 8'h55;
  localparam logic [WORD_W-1:0] NAK_WORD  = 8'hAA;
  localparam logic [WORD_W-1:0] PRON_WORD = 8'h01;   // Protection now on
  localparam logic [WORD_W-1:0] POFF_WORD = 8'h02;   // Protection now off

  localparam logic [WORD_W-1:0] ERASE_KEY = 8'h5A;   // Second byte of an erase

  // Protect and unprotect key pairs
  localparam logic [WORD_W-1:0] PROT_ON_1  = 8'h12;
  localparam logic [WORD_W-1:0] PROT_ON_2  = 8'h56;
  localparam logic [WORD_W-1:0] PROT_OFF_1 = 8'h34;
  localparam logic [WORD_W-1:0] PROT_OFF_2 = 8'h78;

  localparam logic [5:0] PRCH_ADDR = 6'h05;          // Low header bits of a protection change

endpackage
